// ==== Bender.yml ====
package:
  name: c2c_phy

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/c2c_pkg.sv
      - source/c2c_tx_framer.sv
      - source/c2c_rx_decoder.sv
      - source/c2c_link_monitor.sv
      - source/c2c_phy.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/c2c_phy_tb.sv

// ==== include/c2c_settings.svh ====
`ifndef C2C_SETTINGS_SVH
`define C2C_SETTINGS_SVH

// ----------------------------------------------------------------------
// Lane word geometry
// ----------------------------------------------------------------------

// One user word maps onto the 32 data bits of a lane word
`define C2C_DATA_W 32
// One K flag per lane byte
`define C2C_K_W 4

// ----------------------------------------------------------------------
// Code words and their K flag patterns
// ----------------------------------------------------------------------

// Comma K28.5 in byte 0 with 0x50 filler bytes above it
`define C2C_IDLE_WORD 32'h5050_50BC
`define C2C_IDLE_K 4'b0001
// K23.7 repeated in all four bytes
`define C2C_CC_WORD 32'hF7F7_F7F7
`define C2C_CC_K 4'b1111
// Plain data carries no K flags at all
`define C2C_DATA_K 4'b0000

// ----------------------------------------------------------------------
// Clock correction and link thresholds
// ----------------------------------------------------------------------

`define C2C_CC_PERIOD 1024
`define C2C_CC_LEN 4
`define C2C_UP_IDLES 16
`define C2C_BAD_LIMIT 4

`endif

// ==== source/c2c_link_monitor.sv ====
`default_nettype none

`include "c2c_settings.svh"

module c2c_link_monitor
  import c2c_pkg::*;
(
  input  wire logic     gtwiz_userclk_tx_usrclk2_int,
  input  wire logic     link_down_latched_reset_sync,
  input  wire c2c_word_kind_e i_word_kind,
  input  wire logic     i_rx_aligned,
  output logic          o_channel_up,
  output logic          o_link_reset,
  output logic          o_link_down_latched
);

  // ----------------------------------------------------------------------
  // Run counters
  // ----------------------------------------------------------------------

  // Idle run counter saturates at the link-up threshold
  localparam int unsigned IDLE_CNT_W = $clog2(`C2C_UP_IDLES + 1);
  localparam logic [IDLE_CNT_W-1:0] IDLE_MAX = IDLE_CNT_W'(`C2C_UP_IDLES);
  localparam logic [IDLE_CNT_W-1:0] IDLE_LAST = IDLE_CNT_W'(`C2C_UP_IDLES - 1);

  // Bad run counter saturates at the loss threshold
  localparam int unsigned BAD_CNT_W = $clog2(`C2C_BAD_LIMIT + 1);
  localparam logic [BAD_CNT_W-1:0] BAD_MAX = BAD_CNT_W'(`C2C_BAD_LIMIT);
  localparam logic [BAD_CNT_W-1:0] BAD_LAST = BAD_CNT_W'(`C2C_BAD_LIMIT - 1);

  logic [IDLE_CNT_W-1:0] idle_cnt;
  logic [BAD_CNT_W-1:0]  bad_cnt;
  logic                  aligned_idle;
  logic                  word_bad;
  logic                  up_event;
  logic                  loss_event;

  assign aligned_idle = i_rx_aligned & (i_word_kind == IDLE);
  assign word_bad     = (i_word_kind == BAD);

  // The last idle of the run completes it in this very cycle
  assign up_event = ~o_channel_up & aligned_idle & (idle_cnt == IDLE_LAST);

  // Loss only counts while the link is up, so a dead lane pulses reset once
  assign loss_event = o_channel_up &
                      (~i_rx_aligned | (word_bad & (bad_cnt == BAD_LAST)));

  // Alignment loss and bad words break an idle run
  // DATA and CC words leave the run where it is
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      idle_cnt <= '0;
    end else if (~i_rx_aligned | word_bad) begin
      idle_cnt <= '0;
    end else if (aligned_idle && idle_cnt != IDLE_MAX) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // Any word that is not BAD ends a bad run
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      bad_cnt <= '0;
    end else if (~word_bad | loss_event) begin
      bad_cnt <= '0;
    end else if (bad_cnt != BAD_MAX) begin
      bad_cnt <= bad_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Link status
  // ----------------------------------------------------------------------

  // Channel-up, the reset pulse and the latched flag all move together on loss
  // The link reset pulse lasts one cycle because loss needs channel-up high
  // The latched flag is sticky and only the reset input clears it
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      o_channel_up        <= 1'b0;
      o_link_reset        <= 1'b0;
      o_link_down_latched <= 1'b0;
    end else begin
      o_link_reset <= loss_event;
      if (loss_event) begin
        o_channel_up        <= 1'b0;
        o_link_down_latched <= 1'b1;
      end else if (up_event) begin
        o_channel_up <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/c2c_phy.sv ====
`default_nettype none

`include "c2c_settings.svh"

module c2c_phy
  import c2c_pkg::*;
(
  input  wire logic                   gtwiz_userclk_tx_usrclk2_int,
  input  wire logic                   link_down_latched_reset_sync,
  // User transmit stream
  input  wire logic [`C2C_DATA_W-1:0] i_tx_tdata,
  input  wire logic                   i_tx_tvalid,
  output logic                        o_tx_tready,
  // User receive stream, which has no back-pressure
  output logic [`C2C_DATA_W-1:0]      o_rx_tdata,
  output logic                        o_rx_tvalid,
  // Transceiver lane
  output logic [`C2C_DATA_W-1:0]      o_mgt_tx_data,
  output logic [`C2C_K_W-1:0]         o_mgt_tx_k,
  input  wire logic [`C2C_DATA_W-1:0] i_mgt_rx_data,
  input  wire logic [`C2C_K_W-1:0]    i_mgt_rx_k,
  input  wire logic                   i_rx_aligned,
  // Link status
  output logic                        o_channel_up,
  output logic                        o_link_reset,
  output logic                        o_link_down_latched
);

  c2c_lane_word_t tx_lane_word;
  c2c_lane_word_t rx_lane_word;
  c2c_word_kind_e word_kind;
  logic           channel_up;

  // ----------------------------------------------------------------------
  // Lane packing
  // ----------------------------------------------------------------------

  assign o_mgt_tx_data     = tx_lane_word.data;
  assign o_mgt_tx_k        = tx_lane_word.k;
  assign rx_lane_word.data = i_mgt_rx_data;
  assign rx_lane_word.k    = i_mgt_rx_k;

  // ----------------------------------------------------------------------
  // Encode, decode and status blocks
  // ----------------------------------------------------------------------

  c2c_tx_framer i_c2c_tx_framer (
    .gtwiz_userclk_tx_usrclk2_int (gtwiz_userclk_tx_usrclk2_int),
    .link_down_latched_reset_sync (link_down_latched_reset_sync),
    .i_tx_tdata                   (i_tx_tdata),
    .i_tx_tvalid                  (i_tx_tvalid),
    .o_tx_tready                  (o_tx_tready),
    .o_lane_word                  (tx_lane_word)
  );

  // The decoder gates its beats with the registered channel-up state
  c2c_rx_decoder i_c2c_rx_decoder (
    .gtwiz_userclk_tx_usrclk2_int (gtwiz_userclk_tx_usrclk2_int),
    .link_down_latched_reset_sync (link_down_latched_reset_sync),
    .i_lane_word                  (rx_lane_word),
    .i_channel_up                 (channel_up),
    .o_word_kind                  (word_kind),
    .o_rx_tdata                   (o_rx_tdata),
    .o_rx_tvalid                  (o_rx_tvalid)
  );

  c2c_link_monitor i_c2c_link_monitor (
    .gtwiz_userclk_tx_usrclk2_int (gtwiz_userclk_tx_usrclk2_int),
    .link_down_latched_reset_sync (link_down_latched_reset_sync),
    .i_word_kind                  (word_kind),
    .i_rx_aligned                 (i_rx_aligned),
    .o_channel_up                 (channel_up),
    .o_link_reset                 (o_link_reset),
    .o_link_down_latched          (o_link_down_latched)
  );

  assign o_channel_up = channel_up;

endmodule

`default_nettype wire

// ==== source/c2c_pkg.sv ====
`default_nettype none

`include "c2c_settings.svh"

package c2c_pkg;

  // ----------------------------------------------------------------------
  // Lane word
  // ----------------------------------------------------------------------

  // A lane word is what crosses the transceiver each user clock cycle
  // Data sits in the upper bits and the K flags below it
  // Bit i of k marks byte i of data as a control character
  typedef struct packed {
    logic [`C2C_DATA_W-1:0] data;
    logic [`C2C_K_W-1:0]    k;
  } c2c_lane_word_t;

  // ----------------------------------------------------------------------
  // Word classification
  // ----------------------------------------------------------------------

  // Kind of a received lane word as seen by the decoder
  // DATA carries a user beat and has no K flags set
  // IDLE is the comma filler word sent between beats
  // CC is one word of a clock-correction burst
  // BAD covers every K flag pattern or code data that matches none of the above
  typedef enum logic [1:0] {
    DATA = 2'd0,
    IDLE = 2'd1,
    CC   = 2'd2,
    BAD  = 2'd3
  } c2c_word_kind_e;

endpackage

`default_nettype wire

// ==== source/c2c_rx_decoder.sv ====
`default_nettype none

`include "c2c_settings.svh"

module c2c_rx_decoder
  import c2c_pkg::*;
(
  input  wire logic                   gtwiz_userclk_tx_usrclk2_int,
  input  wire logic                   link_down_latched_reset_sync,
  input  wire c2c_lane_word_t         i_lane_word,
  input  wire logic                   i_channel_up,
  output c2c_word_kind_e              o_word_kind,
  output logic [`C2C_DATA_W-1:0]      o_rx_tdata,
  output logic                        o_rx_tvalid
);

  // ----------------------------------------------------------------------
  // Word classification
  // ----------------------------------------------------------------------

  c2c_word_kind_e word_kind;
  logic           rx_beat;

  // The K flags pick the candidate kind and the code data confirms it
  // A control word with the right flags but the wrong code byte is BAD
  // Any K pattern not listed here is BAD as well
  always_comb begin
    word_kind = BAD;
    case (i_lane_word.k)
      `C2C_DATA_K: begin
        word_kind = DATA;
      end
      `C2C_IDLE_K: begin
        if (i_lane_word.data == `C2C_IDLE_WORD) begin
          word_kind = IDLE;
        end
      end
      `C2C_CC_K: begin
        if (i_lane_word.data == `C2C_CC_WORD) begin
          word_kind = CC;
        end
      end
      default: begin
        word_kind = BAD;
      end
    endcase
  end

  // The monitor sees the kind of the word in the same cycle
  assign o_word_kind = word_kind;

  // ----------------------------------------------------------------------
  // User beat delivery
  // ----------------------------------------------------------------------

  // Only data words become beats, and only while the link is up
  // Idle and correction words are stripped here
  assign rx_beat = (word_kind == DATA) & i_channel_up;

  // Valid is control state and comes out of reset low
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      o_rx_tvalid <= 1'b0;
    end else begin
      o_rx_tvalid <= rx_beat;
    end
  end

  // The data register only loads on a delivered beat
  // It keeps the last beat between beats
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (rx_beat) begin
      o_rx_tdata <= i_lane_word.data;
    end
  end

endmodule

`default_nettype wire

// ==== source/c2c_tx_framer.sv ====
`default_nettype none

`include "c2c_settings.svh"

module c2c_tx_framer
  import c2c_pkg::*;
(
  input  wire logic                   gtwiz_userclk_tx_usrclk2_int,
  input  wire logic                   link_down_latched_reset_sync,
  input  wire logic [`C2C_DATA_W-1:0] i_tx_tdata,
  input  wire logic                   i_tx_tvalid,
  output logic                        o_tx_tready,
  output c2c_lane_word_t              o_lane_word
);

  // ----------------------------------------------------------------------
  // Clock-correction counter
  // ----------------------------------------------------------------------

  // The counter spans one full correction period
  localparam int unsigned CNT_W = $clog2(`C2C_CC_PERIOD);
  // Last count before the counter wraps back to zero
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`C2C_CC_PERIOD - 1);
  // First count of the correction window at the end of the period
  localparam logic [CNT_W-1:0] WIN_START = CNT_W'(`C2C_CC_PERIOD - `C2C_CC_LEN);

  logic [CNT_W-1:0] cc_cnt;
  logic [CNT_W-1:0] cc_cnt_next;
  logic             cc_window;
  logic             tx_beat;
  c2c_lane_word_t   lane_word_next;

  // Free-running count from 0 to CNT_LAST
  always_comb begin
    if (cc_cnt == CNT_LAST) begin
      cc_cnt_next = '0;
    end else begin
      cc_cnt_next = cc_cnt + 1'b1;
    end
  end

  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      cc_cnt <= '0;
    end else begin
      cc_cnt <= cc_cnt_next;
    end
  end

  // The window covers the last C2C_CC_LEN counts of each period
  assign cc_window = (cc_cnt >= WIN_START);

  // ----------------------------------------------------------------------
  // User handshake
  // ----------------------------------------------------------------------

  // Ready comes straight from the counter register and never looks at valid
  // The user is held off for exactly the words of the correction burst
  assign o_tx_tready = ~cc_window;

  // A beat moves when both sides agree in the same cycle
  assign tx_beat = i_tx_tvalid & o_tx_tready;

  // ----------------------------------------------------------------------
  // Lane word selection
  // ----------------------------------------------------------------------

  // Beats win over filler, and a window cycle can never carry a beat
  // Correction words are sent in the cycles that follow the window
  // Every other gap is filled with the comma idle so the receiver stays aligned
  always_comb begin
    if (tx_beat) begin
      lane_word_next.data = i_tx_tdata;
      lane_word_next.k    = `C2C_DATA_K;
    end else if (cc_window) begin
      lane_word_next.data = `C2C_CC_WORD;
      lane_word_next.k    = `C2C_CC_K;
    end else begin
      lane_word_next.data = `C2C_IDLE_WORD;
      lane_word_next.k    = `C2C_IDLE_K;
    end
  end

  // The lane output is registered so an accepted beat leaves one cycle later
  // Out of reset the lane carries an idle comma word
  always_ff @(posedge gtwiz_userclk_tx_usrclk2_int) begin
    if (link_down_latched_reset_sync) begin
      o_lane_word.data <= `C2C_IDLE_WORD;
      o_lane_word.k    <= `C2C_IDLE_K;
    end else begin
      o_lane_word <= lane_word_next;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/c2c_pkg.sv
source/c2c_tx_framer.sv
source/c2c_rx_decoder.sv
source/c2c_link_monitor.sv
source/c2c_phy.sv
verification/c2c_phy_tb.sv

// ==== verification/c2c_phy_tb.sv ====
`default_nettype none

`include "c2c_settings.svh"

module c2c_phy_tb;

  // ----------------------------------------------------------------------
  // Run lengths and lane codes
  // ----------------------------------------------------------------------

  localparam int RESET_CYCLES = 10;
  localparam int WAIT_LIMIT = 100;
  // Random traffic long enough to span two correction windows
  localparam int DATA_CYCLES = 2 * `C2C_CC_PERIOD + 64;
  localparam int TIMEOUT_CYCLES = 4 * `C2C_CC_PERIOD + 500;
  // Injected fault word carries a K pattern that no valid word uses
  localparam logic [`C2C_DATA_W-1:0] BAD_DATA = 32'hDEAD_BEEF;
  localparam logic [`C2C_K_W-1:0] BAD_K = 4'b0010;
  localparam int KIND_DATA = 0;
  localparam int KIND_IDLE = 1;
  localparam int KIND_CC = 2;
  localparam int KIND_BAD = 3;

  logic                   gtwiz_userclk_tx_usrclk2_int;
  logic                   link_down_latched_reset_sync;
  logic [`C2C_DATA_W-1:0] i_tx_tdata;
  logic                   i_tx_tvalid;
  logic                   o_tx_tready;
  logic [`C2C_DATA_W-1:0] o_rx_tdata;
  logic                   o_rx_tvalid;
  logic [`C2C_DATA_W-1:0] o_mgt_tx_data;
  logic [`C2C_K_W-1:0]    o_mgt_tx_k;
  wire logic [`C2C_DATA_W-1:0] i_mgt_rx_data;
  wire logic [`C2C_K_W-1:0]    i_mgt_rx_k;
  wire logic              i_rx_aligned;
  logic                   o_channel_up;
  logic                   o_link_reset;
  logic                   o_link_down_latched;

  // Lane model controls, all driven on the falling edge
  logic loop_enable;
  logic force_misalign;
  logic inject_bad;
  integer seed;

  // Reference model state, advanced once per rising edge
  int                     edge_count;
  int                     m_cnt;
  logic [`C2C_DATA_W-1:0] m_lane_data;
  logic [`C2C_K_W-1:0]    m_lane_k;
  logic                   m_up;
  logic                   m_reset;
  logic                   m_latched;
  int                     m_idle_run;
  int                     m_bad_run;
  logic                   up_seen;
  logic                   prev_ready;
  int                     low_run;
  int                     last_win_edge;
  // Scoreboard of accepted beats and the edge that accepted each one
  logic [`C2C_DATA_W-1:0] sb_data[$];
  int                     sb_edge[$];

  always #5 gtwiz_userclk_tx_usrclk2_int = ~gtwiz_userclk_tx_usrclk2_int;

  c2c_phy i_c2c_phy (
    .gtwiz_userclk_tx_usrclk2_int (gtwiz_userclk_tx_usrclk2_int),
    .link_down_latched_reset_sync (link_down_latched_reset_sync),
    .i_tx_tdata                   (i_tx_tdata),
    .i_tx_tvalid                  (i_tx_tvalid),
    .o_tx_tready                  (o_tx_tready),
    .o_rx_tdata                   (o_rx_tdata),
    .o_rx_tvalid                  (o_rx_tvalid),
    .o_mgt_tx_data                (o_mgt_tx_data),
    .o_mgt_tx_k                   (o_mgt_tx_k),
    .i_mgt_rx_data                (i_mgt_rx_data),
    .i_mgt_rx_k                   (i_mgt_rx_k),
    .i_rx_aligned                 (i_rx_aligned),
    .o_channel_up                 (o_channel_up),
    .o_link_reset                 (o_link_reset),
    .o_link_down_latched          (o_link_down_latched)
  );

  // Zero-delay loopback, with an idle word until the TX lane leaves X
  assign i_mgt_rx_data = !loop_enable ? `C2C_IDLE_WORD : (inject_bad ? BAD_DATA : o_mgt_tx_data);
  assign i_mgt_rx_k    = !loop_enable ? `C2C_IDLE_K : (inject_bad ? BAD_K : o_mgt_tx_k);
  assign i_rx_aligned  = ~force_misalign;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %s is 0x%0h, expected 0x%0h", name, got, exp);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  // Lane word kinds as the link protocol defines them
  function automatic int classify(input logic [`C2C_DATA_W-1:0] data,
                                  input logic [`C2C_K_W-1:0] k);
    if (k == 4'b0000) return KIND_DATA;
    if (k == 4'b0001 && data == 32'h5050_50BC) return KIND_IDLE;
    if (k == 4'b1111 && data == 32'hF7F7_F7F7) return KIND_CC;
    return KIND_BAD;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model and checks on every rising edge
  // ----------------------------------------------------------------------

  // All reads here see the values from the cycle before the edge
  always @(posedge gtwiz_userclk_tx_usrclk2_int) begin : check_model
    int   kind;
    logic window;
    logic beat;
    logic loss;
    logic rise;
    if (link_down_latched_reset_sync) begin
      edge_count = 0;
      m_cnt = 0;
      m_lane_data = 32'h5050_50BC;
      m_lane_k = 4'b0001;
      m_up = 1'b0;
      m_reset = 1'b0;
      m_latched = 1'b0;
      m_idle_run = 0;
      m_bad_run = 0;
      up_seen = 1'b0;
      prev_ready = 1'b1;
      low_run = 0;
      last_win_edge = 0;
      sb_data.delete();
      sb_edge.delete();
    end else begin
      edge_count++;
      window = (m_cnt >= `C2C_CC_PERIOD - `C2C_CC_LEN);
      assert (o_tx_tready === !window)
        else report_mismatch("o_tx_tready", o_tx_tready, !window);
      assert (o_mgt_tx_data === m_lane_data)
        else report_mismatch("o_mgt_tx_data", o_mgt_tx_data, m_lane_data);
      assert (o_mgt_tx_k === m_lane_k)
        else report_mismatch("o_mgt_tx_k", o_mgt_tx_k, m_lane_k);
      assert (o_channel_up === m_up)
        else report_mismatch("o_channel_up", o_channel_up, m_up);
      assert (o_link_reset === m_reset)
        else report_mismatch("o_link_reset", o_link_reset, m_reset);
      assert (o_link_down_latched === m_latched)
        else report_mismatch("o_link_down_latched", o_link_down_latched, m_latched);
      // First rise of channel-up after reset lands on a fixed edge
      if (o_channel_up === 1'b1 && !up_seen) begin
        up_seen = 1'b1;
        assert (edge_count == `C2C_UP_IDLES + 1)
          else report_error("channel-up rose on the wrong cycle after reset");
      end
      // Each back-pressure run is one burst long and starts once per period
      if (o_tx_tready === 1'b0) begin
        low_run++;
        if (prev_ready && last_win_edge != 0) begin
          assert (edge_count - last_win_edge == `C2C_CC_PERIOD)
            else report_error("correction bursts are not one period apart");
        end
        if (prev_ready) last_win_edge = edge_count;
      end else if (low_run != 0) begin
        assert (low_run == `C2C_CC_LEN)
          else report_error("back-pressure run differs from the burst length");
        low_run = 0;
      end
      prev_ready = o_tx_tready;
      // Every RX beat must match the oldest accepted beat, two edges on
      if (o_rx_tvalid === 1'b1) begin
        assert (sb_data.size() > 0)
          else report_error("RX valid with no accepted beat pending");
        assert (sb_edge[0] + 2 == edge_count)
          else report_error("RX beat arrived with the wrong latency");
        assert (o_rx_tdata === sb_data[0])
          else report_mismatch("o_rx_tdata", o_rx_tdata, sb_data[0]);
        void'(sb_data.pop_front());
        void'(sb_edge.pop_front());
      end else begin
        assert (o_rx_tvalid === 1'b0)
          else report_mismatch("o_rx_tvalid", o_rx_tvalid, 1'b0);
        if (sb_edge.size() > 0) begin
          assert (sb_edge[0] + 2 != edge_count)
            else report_error("an accepted beat never reached the RX stream");
        end
      end
      // Framer rules for the next lane word
      beat = (i_tx_tvalid === 1'b1) && !window;
      if (beat) begin
        m_lane_data = i_tx_tdata;
        m_lane_k = 4'b0000;
      end else if (window) begin
        m_lane_data = 32'hF7F7_F7F7;
        m_lane_k = 4'b1111;
      end else begin
        m_lane_data = 32'h5050_50BC;
        m_lane_k = 4'b0001;
      end
      m_cnt = (m_cnt == `C2C_CC_PERIOD - 1) ? 0 : m_cnt + 1;
      // Monitor rules from the word now on the RX lane
      kind = classify(i_mgt_rx_data, i_mgt_rx_k);
      loss = m_up && (!i_rx_aligned || (kind == KIND_BAD && m_bad_run == `C2C_BAD_LIMIT - 1));
      rise = !m_up && i_rx_aligned && kind == KIND_IDLE && m_idle_run == `C2C_UP_IDLES - 1;
      if (!i_rx_aligned || kind == KIND_BAD) m_idle_run = 0;
      else if (kind == KIND_IDLE && m_idle_run < `C2C_UP_IDLES) m_idle_run++;
      if (kind != KIND_BAD || loss) m_bad_run = 0;
      else if (m_bad_run < `C2C_BAD_LIMIT) m_bad_run++;
      m_reset = loss;
      if (loss) begin
        m_up = 1'b0;
        m_latched = 1'b1;
      end else if (rise) begin
        m_up = 1'b1;
      end
      // A beat only reaches the RX stream if the link is up when its word arrives
      if (beat && m_up) begin
        sb_data.push_back(i_tx_tdata);
        sb_edge.push_back(edge_count);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Waits with a cycle limit
  // ----------------------------------------------------------------------

  task automatic wait_channel_up();
    int n;
    n = 0;
    while (o_channel_up !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge gtwiz_userclk_tx_usrclk2_int);
      n++;
    end
    if (o_channel_up !== 1'b1) report_error("channel-up did not rise in time");
  endtask

  task automatic wait_link_reset();
    int n;
    n = 0;
    while (o_link_reset !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge gtwiz_userclk_tx_usrclk2_int);
      n++;
    end
    if (o_link_reset !== 1'b1) report_error("link reset did not pulse after a fault");
  endtask

  task automatic wait_rx_drain();
    int n;
    n = 0;
    while (sb_data.size() > 0 && n < WAIT_LIMIT) begin
      @(negedge gtwiz_userclk_tx_usrclk2_int);
      n++;
    end
    if (sb_data.size() > 0) report_error("accepted beats still pending on the RX stream");
  endtask

  // Drives random beats and holds each one until the framer takes it
  task automatic send_beats(input int count);
    int j;
    for (j = 0; j < count; j++) begin
      i_tx_tvalid = 1'b1;
      i_tx_tdata = $random(seed);
      while (o_tx_tready !== 1'b1) begin
        @(negedge gtwiz_userclk_tx_usrclk2_int);
      end
      @(negedge gtwiz_userclk_tx_usrclk2_int);
    end
    i_tx_tvalid = 1'b0;
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge gtwiz_userclk_tx_usrclk2_int);
    report_error("watchdog expired before the test sequence finished");
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin : stimulus
    int   i;
    logic last_ready;
    seed = 32'h72a6;
    gtwiz_userclk_tx_usrclk2_int = 1'b0;
    link_down_latched_reset_sync = 1'b1;
    i_tx_tdata = '0;
    i_tx_tvalid = 1'b0;
    loop_enable = 1'b0;
    force_misalign = 1'b0;
    inject_bad = 1'b0;
    @(negedge gtwiz_userclk_tx_usrclk2_int);
    loop_enable = 1'b1;
    repeat (RESET_CYCLES - 1) @(negedge gtwiz_userclk_tx_usrclk2_int);
    link_down_latched_reset_sync = 1'b0;
    wait_channel_up();
    // Random traffic; a beat that met back-pressure is held unchanged
    last_ready = 1'b1;
    for (i = 0; i < DATA_CYCLES; i++) begin
      if (!(i_tx_tvalid && !last_ready)) begin
        i_tx_tvalid = ($random(seed) & 3) != 0;
        i_tx_tdata = $random(seed);
      end
      last_ready = o_tx_tready;
      @(negedge gtwiz_userclk_tx_usrclk2_int);
    end
    while (i_tx_tvalid && !last_ready) begin
      last_ready = o_tx_tready;
      @(negedge gtwiz_userclk_tx_usrclk2_int);
    end
    i_tx_tvalid = 1'b0;
    wait_rx_drain();
    // Alignment lost for a single cycle
    force_misalign = 1'b1;
    @(negedge gtwiz_userclk_tx_usrclk2_int);
    force_misalign = 1'b0;
    wait_link_reset();
    // Beats sent while the link is down must not reach the RX stream
    send_beats(4);
    wait_channel_up();
    assert (o_link_down_latched === 1'b1)
      else report_mismatch("o_link_down_latched", o_link_down_latched, 1'b1);
    // A run of bad words just long enough to drop the link
    inject_bad = 1'b1;
    repeat (`C2C_BAD_LIMIT) @(negedge gtwiz_userclk_tx_usrclk2_int);
    inject_bad = 1'b0;
    wait_link_reset();
    wait_channel_up();
    assert (o_link_down_latched === 1'b1)
      else report_mismatch("o_link_down_latched", o_link_down_latched, 1'b1);
    // Only reset clears the sticky flag
    link_down_latched_reset_sync = 1'b1;
    repeat (RESET_CYCLES) @(negedge gtwiz_userclk_tx_usrclk2_int);
    link_down_latched_reset_sync = 1'b0;
    assert (o_link_down_latched === 1'b0)
      else report_mismatch("o_link_down_latched", o_link_down_latched, 1'b0);
    wait_channel_up();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
